// File: hw/tg_pkg.sv
package tg_pkg;

    ////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////

    localparam int ADDR_W = 33;  // HBM pseudo-channel address
    localparam int DATA_W = 256;
    localparam int LEN_W  = 4;   // AXI3 style burst length
    localparam int CNT_W  = 6;   // Outstanding and credit counters

    ////////////////////////////////////////
    // Address map and burst attributes
    ////////////////////////////////////////

    // Each generator owns one 256 MB region
    localparam logic [ADDR_W-1:0] REGION_SIZE = 33'h0_1000_0000;
    localparam logic [ADDR_W-1:0] WRAP_OFFSET = 33'h0_0FFF_FC00;  // Last stepped address
    localparam logic [ADDR_W-1:0] ADDR_STEP   = 33'h0_0000_0200;  // 16 beats of 32 bytes

    localparam logic [31:0] DATA_PATTERN = 32'hA5A5_A5A5;
    localparam logic [2:0]  SIZE_CODE    = 3'd5;   // 32 bytes per beat
    localparam logic [1:0]  BURST_INCR   = 2'b01;

    // Queued modes only, anything else leaves the generator idle
    typedef enum logic [2:0] {
        MODE_QREAD  = 3'd3,
        MODE_QWRITE = 3'd4
    } tg_mode_e;

    ////////////////////////////////////////
    // Stage interfaces
    ////////////////////////////////////////

    typedef struct packed {
        logic             run;       // Start and this port's mask bit
        tg_mode_e         mode;
        logic             addr_inc;
        logic [LEN_W-1:0] len;       // Beats minus one
    } tg_cfg_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } tg_cmd_t;

endpackage

// File: hw/tg_addr_gen.sv
`timescale 1ns/10ps

module tg_addr_gen #(
    parameter int GEN_INDEX = 0
) (
    input  logic             axi_aclk,
    input  logic             axi_aresetn,
    input  tg_pkg::tg_cfg_t  cfg,
    input  logic             adv,
    output tg_pkg::tg_cmd_t  cmd
);

    import tg_pkg::*;

    // Region base and the highest address that may still step
    localparam logic [ADDR_W-1:0] BASE  = ADDR_W'(GEN_INDEX) * REGION_SIZE;
    localparam logic [ADDR_W-1:0] LIMIT = BASE + WRAP_OFFSET;

    logic [ADDR_W-1:0] cur_addr;
    logic [ADDR_W-1:0] next_addr;

    ////////////////////////////////////////
    // Next burst address
    ////////////////////////////////////////

    always_comb
    begin
        if (!cfg.addr_inc)
        begin
            next_addr = BASE;  // Hammer the same burst
        end
        else if (cur_addr <= LIMIT)
        begin
            next_addr = cur_addr + ADDR_STEP;
        end
        else
        begin
            // Ran past the limit, start over at the base
            next_addr = BASE;
        end
    end

    // Updated one cycle after the handshake, while issue sits in SETTLE
    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            cur_addr <= BASE;
        end
        else if (adv)
        begin
            cur_addr <= next_addr;
        end
    end

    assign cmd = '{addr: cur_addr, len: cfg.len};

endmodule

// File: hw/tg_cmd_issue.sv
`timescale 1ns/10ps

module tg_cmd_issue #(
    parameter int MAX_OUTSTANDING = 11
) (
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,
    input  tg_pkg::tg_cfg_t          cfg,
    input  tg_pkg::tg_cmd_t          cmd,
    input  logic                     axi_arready,
    input  logic                     axi_awready,
    input  logic                     retire,
    output logic                     axi_arvalid,
    output logic                     axi_awvalid,
    output logic                     adv,
    output logic                     aw_accept,
    output logic                     txn_pulse,
    output logic [tg_pkg::CNT_W-1:0] outstanding
);

    import tg_pkg::*;

    localparam logic [CNT_W-1:0] CAP = CNT_W'(MAX_OUTSTANDING);

    typedef enum logic [1:0] {IDLE, VALID, SETTLE} state_e;

    state_e state;
    state_e state_next;
    logic   go;
    logic   room;
    logic   ar_hs;
    logic   aw_hs;
    logic   hs;

    assign go   = cfg.run && (cfg.mode == MODE_QREAD || cfg.mode == MODE_QWRITE);
    assign room = outstanding < CAP;

    // Valid drops at once when run falls, the bursts in flight still drain
    assign axi_arvalid = (state == VALID) && cfg.run && (cfg.mode == MODE_QREAD);
    assign axi_awvalid = (state == VALID) && cfg.run && (cfg.mode == MODE_QWRITE);

    assign ar_hs = axi_arvalid && axi_arready;
    assign aw_hs = axi_awvalid && axi_awready;
    assign hs    = ar_hs || aw_hs;

    assign adv       = (state == SETTLE);  // One cycle after each handshake
    assign txn_pulse = adv;

    ////////////////////////////////////////
    // Issue FSM
    ////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (go && room)
                    state_next = VALID;
            end
            VALID:
            begin
                if (!go)
                    state_next = IDLE;
                else if (hs)
                    state_next = SETTLE;
            end
            SETTLE:
            begin
                // Address generator steps during this cycle
                if (go && room)
                    state_next = VALID;
                else
                    state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            state       <= IDLE;
            aw_accept   <= 1'b0;
            outstanding <= '0;
        end
        else
        begin
            state     <= state_next;
            aw_accept <= aw_hs;  // Hands a data credit to the W stage
            if (hs && !retire)
                outstanding <= outstanding + 1'b1;
            else if (retire && !hs && outstanding != '0)
                outstanding <= outstanding - 1'b1;
        end
    end

endmodule

// File: hw/tg_wdata_stage.sv
`timescale 1ns/10ps

module tg_wdata_stage (
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,
    input  logic [tg_pkg::LEN_W-1:0] len,
    input  logic                     aw_accept,
    input  logic                     axi_wready,
    output logic                     axi_wvalid,
    output logic                     axi_wlast
);

    import tg_pkg::*;

    logic [CNT_W-1:0] credits;  // Accepted AW still waiting for data
    logic [LEN_W-1:0] beat;
    logic             busy;
    logic             start;
    logic             beat_done;

    assign start     = !busy && (credits != '0);
    assign beat_done = axi_wvalid && axi_wready;

    assign axi_wvalid = busy;
    assign axi_wlast  = busy && (beat == len);

    ////////////////////////////////////////
    // Write data credits
    ////////////////////////////////////////

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            credits <= '0;
        end
        else
        begin
            case ({aw_accept, start})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;  // None or both
            endcase
        end
    end

    // Beat sequencer, one burst per credit
    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            busy <= 1'b0;
            beat <= '0;
        end
        else if (start)
        begin
            busy <= 1'b1;
            beat <= '0;
        end
        else if (beat_done)
        begin
            if (axi_wlast)
            begin
                busy <= 1'b0;
                beat <= '0;
            end
            else
            begin
                beat <= beat + 1'b1;
            end
        end
    end

endmodule

// File: hw/tg_resp_stage.sv
`timescale 1ns/10ps

module tg_resp_stage (
    input  logic              axi_aclk,
    input  logic              axi_aresetn,
    input  tg_pkg::tg_mode_e  mode,
    input  logic              axi_rvalid,
    input  logic              axi_rlast,
    input  logic              axi_bvalid,
    output logic              axi_rready,
    output logic              axi_bready,
    output logic              retire
);

    import tg_pkg::*;

    logic r_done;
    logic b_done;

    // Read burst finishes on its last accepted beat
    assign r_done = axi_rvalid && axi_rready && axi_rlast;
    assign b_done = axi_bvalid && axi_bready;

    ////////////////////////////////////////
    // Ready levels and retire pulse
    ////////////////////////////////////////

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            axi_rready <= 1'b0;
            axi_bready <= 1'b0;
        end
        else
        begin
            // Held for the whole mode so a stopped run still drains
            axi_rready <= (mode == MODE_QREAD);
            axi_bready <= (mode == MODE_QWRITE);
        end
    end

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            retire <= 1'b0;
        end
        else
        begin
            retire <= r_done || b_done;  // Frees one outstanding slot
        end
    end

endmodule

// File: hw/traffic_gen.sv
`timescale 1ns/10ps

module traffic_gen #(
    parameter int GEN_INDEX       = 0,
    parameter int MAX_OUTSTANDING = 11
) (
    input  logic                          axi_aclk,
    input  logic                          axi_aresetn,

    // Shared control levels
    input  logic                          csr_start,
    input  logic [2:0]                    read_or_write,
    input  logic                          address_inc_csr,
    input  logic [31:0]                   port_mask,
    input  logic [tg_pkg::LEN_W-1:0]      transaction_length,
    output logic                          txn_pulse,

    // Read address
    output logic [tg_pkg::ADDR_W-1:0]     axi_araddr,
    output logic [tg_pkg::LEN_W-1:0]      axi_arlen,
    output logic [2:0]                    axi_arsize,
    output logic [1:0]                    axi_arburst,
    output logic                          axi_arvalid,
    input  logic                          axi_arready,

    // Write address and data
    output logic [tg_pkg::ADDR_W-1:0]     axi_awaddr,
    output logic [tg_pkg::LEN_W-1:0]      axi_awlen,
    output logic [2:0]                    axi_awsize,
    output logic [1:0]                    axi_awburst,
    output logic                          axi_awvalid,
    input  logic                          axi_awready,
    output logic [tg_pkg::DATA_W-1:0]     axi_wdata,
    output logic [tg_pkg::DATA_W/8-1:0]   axi_wstrb,
    output logic                          axi_wvalid,
    output logic                          axi_wlast,
    input  logic                          axi_wready,

    // Read data and write response
    input  logic                          axi_rvalid,
    input  logic                          axi_rlast,
    output logic                          axi_rready,
    input  logic                          axi_bvalid,
    output logic                          axi_bready
);

    import tg_pkg::*;

    tg_cfg_t          cfg;
    tg_cmd_t          cmd;
    logic             adv;
    logic             aw_accept;
    logic             retire;

    assign cfg = '{
        run:      csr_start && port_mask[GEN_INDEX],
        mode:     tg_mode_e'(read_or_write),
        addr_inc: address_inc_csr,
        len:      transaction_length
    };

    ////////////////////////////////////////
    // Fixed AXI attributes
    ////////////////////////////////////////

    assign axi_araddr  = cmd.addr;
    assign axi_awaddr  = cmd.addr;  // Only one direction is active at a time
    assign axi_arlen   = cmd.len;
    assign axi_awlen   = cmd.len;
    assign axi_arsize  = SIZE_CODE;
    assign axi_awsize  = SIZE_CODE;
    assign axi_arburst = BURST_INCR;
    assign axi_awburst = BURST_INCR;
    assign axi_wdata   = {(DATA_W/32){DATA_PATTERN}};
    assign axi_wstrb   = '1;

    ////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////

    tg_addr_gen #(
        .GEN_INDEX (GEN_INDEX)
    ) i_addr_gen (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .cfg         (cfg),
        .adv         (adv),
        .cmd         (cmd)
    );

    tg_cmd_issue #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) i_cmd_issue (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .cfg         (cfg),
        .cmd         (cmd),
        .axi_arready (axi_arready),
        .axi_awready (axi_awready),
        .retire      (retire),
        .axi_arvalid (axi_arvalid),
        .axi_awvalid (axi_awvalid),
        .adv         (adv),
        .aw_accept   (aw_accept),
        .txn_pulse   (txn_pulse),
        .outstanding ()
    );

    tg_wdata_stage i_wdata_stage (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .len         (cmd.len),
        .aw_accept   (aw_accept),
        .axi_wready  (axi_wready),
        .axi_wvalid  (axi_wvalid),
        .axi_wlast   (axi_wlast)
    );

    tg_resp_stage i_resp_stage (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .mode        (cfg.mode),
        .axi_rvalid  (axi_rvalid),
        .axi_rlast   (axi_rlast),
        .axi_bvalid  (axi_bvalid),
        .axi_rready  (axi_rready),
        .axi_bready  (axi_bready),
        .retire      (retire)
    );

endmodule

// File: dv/traffic_gen_props.sv
`timescale 1ns/10ps

module traffic_gen_props #(
    parameter int MAX_OUTSTANDING = 11
) (
    input logic                     axi_aclk,
    input logic                     axi_aresetn,
    input tg_pkg::tg_cfg_t          cfg,
    input logic                     axi_arvalid,
    input logic                     axi_awvalid,
    input logic                     axi_arready,
    input logic                     axi_awready,
    input logic [tg_pkg::CNT_W-1:0] outstanding
);

    import tg_pkg::*;

    ////////////////////////////////////////
    // Issue rules
    ////////////////////////////////////////

    cap_held: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        outstanding <= MAX_OUTSTANDING)
        else $error("outstanding above the cap");

    // No new address once the cap is reached
    no_valid_at_cap: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (axi_arvalid || axi_awvalid) |-> outstanding < MAX_OUTSTANDING)
        else $error("address valid with no room left");

    ar_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        axi_arvalid && !axi_arready |=> axi_arvalid || !cfg.run)
        else $error("arvalid dropped before its handshake");

    aw_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        axi_awvalid && !axi_awready |=> axi_awvalid || !cfg.run)
        else $error("awvalid dropped before its handshake");

endmodule

bind tg_cmd_issue traffic_gen_props #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
) i_props (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .cfg         (cfg),
    .axi_arvalid (axi_arvalid),
    .axi_awvalid (axi_awvalid),
    .axi_arready (axi_arready),
    .axi_awready (axi_awready),
    .outstanding (outstanding)
);

// File: dv/traffic_gen_tb.sv
`timescale 1ns/10ps

module traffic_gen_tb;

    import tg_pkg::*;

    localparam int SEED        = 64;
    localparam int PERIOD      = 100;
    localparam int GEN         = 2;
    localparam int CAP         = 11;
    localparam int READY_PCT   = 70;  // Random ready and response odds
    localparam int WRAP_BURSTS = 32'h8_0000 + 4;  // Enough bursts to step past the limit
    localparam int CYCLE_LIMIT = WRAP_BURSTS * 4 + 40000;

    localparam logic [ADDR_W-1:0]   TB_BASE  = 33'h0_2000_0000;
    localparam logic [ADDR_W-1:0]   TB_LIMIT = TB_BASE + 33'h0_0FFF_FC00;
    localparam logic [ADDR_W-1:0]   TB_STEP  = 33'h0_0000_0200;
    localparam logic [DATA_W-1:0]   TB_WDATA = {8{32'hA5A5_A5A5}};
    localparam logic [DATA_W/8-1:0] TB_WSTRB = '1;
    localparam logic [2:0]          TB_SIZE  = 3'd5;   // 32 bytes per beat
    localparam logic [1:0]          TB_BURST = 2'b01;  // INCR

    logic                axi_aclk = 1'b0;
    logic                axi_aresetn;
    logic                csr_start;
    logic [2:0]          read_or_write;
    logic                address_inc_csr;
    logic [31:0]         port_mask;
    logic [LEN_W-1:0]    transaction_length;
    logic                txn_pulse;
    logic [ADDR_W-1:0]   axi_araddr;
    logic [LEN_W-1:0]    axi_arlen;
    logic [2:0]          axi_arsize;
    logic [1:0]          axi_arburst;
    logic                axi_arvalid;
    logic                axi_arready;
    logic [ADDR_W-1:0]   axi_awaddr;
    logic [LEN_W-1:0]    axi_awlen;
    logic [2:0]          axi_awsize;
    logic [1:0]          axi_awburst;
    logic                axi_awvalid;
    logic                axi_awready;
    logic [DATA_W-1:0]   axi_wdata;
    logic [DATA_W/8-1:0] axi_wstrb;
    logic                axi_wvalid;
    logic                axi_wlast;
    logic                axi_wready;
    logic                axi_rvalid;
    logic                axi_rlast;
    logic                axi_rready;
    logic                axi_bvalid;
    logic                axi_bready;

    // Scoreboard state
    logic [ADDR_W-1:0] exp_addr = TB_BASE;
    int unsigned       rq[$];     // Beats of reads waiting for R
    int unsigned       wq[$];     // Beats of writes waiting for W
    int unsigned       issued = 0;
    int unsigned       completed = 0;
    int unsigned       max_out = 0;
    int unsigned       b_owed = 0;
    int unsigned       w_beat = 0;
    int unsigned       r_left = 0;
    int unsigned       errors = 0;
    int unsigned       checks = 0;
    int unsigned       tests = 0;
    int unsigned       cycles = 0;
    int                ready_pct = READY_PCT;
    logic              resp_en = 1'b1;
    logic              pulse_due = 1'b0;
    logic              wrap_seen = 1'b0;
    logic              r_fired = 1'b0;
    logic              b_fired = 1'b0;

    traffic_gen #(
        .GEN_INDEX (GEN)
    ) i_traffic_gen (.*);

    always #(PERIOD/2) axi_aclk = ~axi_aclk;

    // Base, step and wrap rule for the next burst
    function automatic logic [ADDR_W-1:0] next_addr(logic [ADDR_W-1:0] cur, logic inc);
        if (!inc)
            return TB_BASE;
        if (cur <= TB_LIMIT)
            return cur + TB_STEP;
        return TB_BASE;
    endfunction

    function automatic logic chance(int pct);
        return ($urandom % 100) < pct;
    endfunction

    //////////////////////////////////////////
    // Compare process
    //////////////////////////////////////////

    always @(posedge axi_aclk)
    begin
        logic             ar_fire;
        logic             aw_fire;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len_got;
        logic [2:0]        size_got;
        logic [1:0]        burst_got;
        ar_fire = axi_arvalid && axi_arready;
        aw_fire = axi_awvalid && axi_awready;
        addr    = ar_fire ? axi_araddr : axi_awaddr;
        len_got   = ar_fire ? axi_arlen : axi_awlen;
        size_got  = ar_fire ? axi_arsize : axi_awsize;
        burst_got = ar_fire ? axi_arburst : axi_awburst;
        r_fired = axi_rvalid && axi_rready;
        b_fired = axi_bvalid && axi_bready;
        if (axi_aresetn)
        begin
            checks++;
            if (txn_pulse !== pulse_due)
            begin
                $display("FAIL t=%0t txn_pulse got %b exp %b", $time, txn_pulse, pulse_due);
                errors++;
            end
            pulse_due = ar_fire || aw_fire;
            if (!port_mask[GEN] && (axi_arvalid || axi_awvalid))
            begin
                $display("Address valid rose at %0t with the mask bit clear", $time);
                errors++;
            end
            if ((ar_fire || aw_fire) && !csr_start)
            begin
                $display("Address accepted at %0t after start fell", $time);
                errors++;
            end
            if (ar_fire || aw_fire)
            begin
                checks++;
                if (addr !== exp_addr)
                begin
                    $display("FAIL t=%0t %s got %h exp %h", $time,
                             ar_fire ? "axi_araddr" : "axi_awaddr", addr, exp_addr);
                    errors++;
                end
                if (len_got !== transaction_length)
                begin
                    $display("FAIL t=%0t %s got %h exp %h", $time,
                             ar_fire ? "axi_arlen" : "axi_awlen", len_got, transaction_length);
                    errors++;
                end
                if (size_got !== TB_SIZE)
                begin
                    $display("FAIL t=%0t %s got %h exp %h", $time,
                             ar_fire ? "axi_arsize" : "axi_awsize", size_got, TB_SIZE);
                    errors++;
                end
                if (burst_got !== TB_BURST)
                begin
                    $display("FAIL t=%0t %s got %h exp %h", $time,
                             ar_fire ? "axi_arburst" : "axi_awburst", burst_got, TB_BURST);
                    errors++;
                end
                if (addr == TB_BASE && issued > 0 && exp_addr == TB_BASE && address_inc_csr)
                    wrap_seen = 1'b1;
                exp_addr = next_addr(exp_addr, address_inc_csr);
                issued++;
                if (ar_fire)
                    rq.push_back(axi_arlen + 1);
                else
                    wq.push_back(transaction_length + 1);
            end
            if (axi_wvalid && axi_wready)
            begin
                checks++;
                if (axi_wdata !== TB_WDATA)
                begin
                    $display("FAIL t=%0t axi_wdata got %h exp %h", $time, axi_wdata, TB_WDATA);
                    errors++;
                end
                if (axi_wstrb !== TB_WSTRB)
                begin
                    $display("FAIL t=%0t axi_wstrb got %h exp %h", $time, axi_wstrb, TB_WSTRB);
                    errors++;
                end
                if (wq.size() == 0)
                begin
                    $display("Write beat at %0t with no accepted write address", $time);
                    errors++;
                end
                else if (axi_wlast !== (w_beat + 1 == wq[0]))
                begin
                    $display("FAIL t=%0t axi_wlast got %b exp %b", $time, axi_wlast,
                             w_beat + 1 == wq[0]);
                    errors++;
                end
                w_beat++;
                if (axi_wlast)
                begin
                    void'(wq.pop_front());
                    w_beat = 0;
                    b_owed++;
                end
            end
            if (r_fired && axi_rlast)
                completed++;
            if (b_fired)
                completed++;
            if (issued - completed > CAP)
            begin
                $display("FAIL t=%0t outstanding got %0d exp <= %0d", $time,
                         issued - completed, CAP);
                errors++;
            end
            if (issued - completed > max_out)
                max_out = issued - completed;
        end
    end

    //////////////////////////////////////////
    // Slave model, driven on the falling edge
    //////////////////////////////////////////

    always @(negedge axi_aclk)
    begin
        if (axi_aresetn)
        begin
            axi_arready = chance(ready_pct);
            axi_awready = chance(ready_pct);
            axi_wready  = chance(ready_pct);
            if (axi_rvalid && r_fired)
            begin
                if (axi_rlast)
                    axi_rvalid = 1'b0;
                else
                begin
                    r_left--;
                    axi_rlast = (r_left == 1);
                end
            end
            if (!axi_rvalid && rq.size() > 0 && resp_en && chance(ready_pct))
            begin
                r_left     = rq.pop_front();
                axi_rvalid = 1'b1;
                axi_rlast  = (r_left == 1);
            end
            if (axi_bvalid && b_fired)
            begin
                axi_bvalid = 1'b0;
                b_owed--;
            end
            if (!axi_bvalid && b_owed > 0 && resp_en && chance(ready_pct))
                axi_bvalid = 1'b1;
        end
    end

    always @(posedge axi_aclk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, the run hung", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic drain();
        while (completed != issued)
            @(negedge axi_aclk);
        repeat (4) @(negedge axi_aclk);
    endtask

    task automatic report(string name, int unsigned errs_before);
        tests++;
        $display("test %s: %0d errors, %0d bursts so far", name, errors - errs_before, issued);
    endtask

    task automatic burst_test(string name, logic [2:0] mode, logic inc, logic [LEN_W-1:0] len,
                              int unsigned n, int pct);
        int unsigned errs_before;
        int unsigned target;
        errs_before        = errors;
        @(negedge axi_aclk);
        read_or_write      = mode;
        address_inc_csr    = inc;
        transaction_length = len;
        ready_pct          = pct;
        target             = issued + n;
        csr_start          = 1'b1;
        while (issued < target)
            @(negedge axi_aclk);
        csr_start = 1'b0;
        drain();
        report(name, errs_before);
    endtask

    initial
    begin
        int unsigned errs_before;
        void'($urandom(SEED));
        axi_aresetn        = 1'b0;
        csr_start          = 1'b0;
        read_or_write      = 3'd0;
        address_inc_csr    = 1'b1;
        port_mask          = 32'hFFFF_FFFF;
        transaction_length = '0;
        axi_arready        = 1'b0;
        axi_awready        = 1'b0;
        axi_wready         = 1'b0;
        axi_rvalid         = 1'b0;
        axi_rlast          = 1'b0;
        axi_bvalid         = 1'b0;
        repeat (16) @(negedge axi_aclk);
        axi_aresetn = 1'b1;

        burst_test("qread_inc", 3'd3, 1'b1, 4'd3, 40, READY_PCT);
        burst_test("wrap", 3'd3, 1'b1, 4'd0, WRAP_BURSTS, 100);
        if (!wrap_seen)
        begin
            $display("Address never wrapped back to the region base");
            errors++;
        end
        burst_test("qread_no_inc", 3'd3, 1'b0, 4'd2, 20, READY_PCT);
        burst_test("qwrite", 3'd4, 1'b1, 4'd7, 30, READY_PCT);

        // Outstanding cap with responses held back
        errs_before = errors;
        max_out     = 0;
        resp_en     = 1'b0;
        ready_pct   = READY_PCT;
        read_or_write = 3'd3;
        csr_start   = 1'b1;
        repeat (300) @(negedge axi_aclk);
        if (max_out != CAP)
        begin
            $display("Outstanding reached %0d and not the cap of %0d", max_out, CAP);
            errors++;
        end
        csr_start = 1'b0;
        resp_en   = 1'b1;
        drain();
        report("cap", errs_before);

        // Mask bit clear keeps the generator idle
        errs_before   = errors;
        port_mask[GEN] = 1'b0;
        read_or_write = 3'd4;
        csr_start     = 1'b1;
        repeat (200) @(negedge axi_aclk);
        csr_start      = 1'b0;
        port_mask[GEN] = 1'b1;
        drain();
        report("mask", errs_before);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: build.f
hw/tg_pkg.sv
hw/tg_addr_gen.sv
hw/tg_cmd_issue.sv
hw/tg_wdata_stage.sv
hw/tg_resp_stage.sv
hw/traffic_gen.sv
dv/traffic_gen_props.sv
dv/traffic_gen_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the traffic generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module traffic_gen_tb -f build.f -o sim_traffic_gen
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_traffic_gen > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
